/* Makefile */
# Verilator build and run of the main cpu bus testbench

VERILATOR ?= verilator
FILELIST  ?= pipibibs_bus.f
TB_TOP    ?= tb_pipibibs_bus
RTL_TOP   ?= pipibibs_bus
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* bus_decode.sv */
// registered address decode of the strobed cpu access
`timescale 1ns/1ps
`default_nettype none
`include "pipibibs_bus_settings.svh"

module bus_decode (
    input  wire logic        clk96,
    input  wire logic        reset96,
    input  wire logic        as_n,
    input  wire logic        uds_n,
    input  wire logic        lds_n,
    input  wire logic        rw,
    input  wire logic [23:1] addr,
    input  wire logic [15:0] wdata,
    cpu_req_if.src           req
);
    import pipibibs_bus_pkg::*;

    localparam logic [23:0] rom_top     = `ROM_TOP;
    localparam logic [23:0] wram_base   = `WRAM_BASE;
    localparam logic [23:0] palram_base = `PALRAM_BASE;
    localparam logic [23:0] gcu_base    = `GCU_BASE;
    localparam logic [23:0] sram_base   = `SRAM_BASE;
    localparam logic [23:0] io_base     = `IO_BASE;

    logic [23:0] byte_addr;
    region_t     hit;
    logic        strobe;    // as_n was low at the last edge

    assign byte_addr = {addr, 1'b0}; // easier to read against the map

    always_comb begin
        if (byte_addr < rom_top)                         hit = ROM;
        else if (byte_addr[23:16] == wram_base[23:16])   hit = WRAM;
        else if (byte_addr[23:12] == palram_base[23:12]) hit = PALRAM;
        else if (byte_addr[23:16] == gcu_base[23:16])    hit = GCU;
        else if (byte_addr[23:12] == sram_base[23:12])   hit = SRAM;
        else if (byte_addr[23:12] == io_base[23:12])     hit = IO;
        else                                             hit = NONE;
    end

    // region follows the strobe, valid trails it by one edge
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            strobe     <= 1'b0;
            req.valid  <= 1'b0;
            req.region <= NONE;
        end else begin
            strobe     <= ~as_n;
            req.valid  <= strobe;
            req.region <= as_n ? NONE : hit;
        end
    end

    // access details, qualified by valid downstream
    always_ff @(posedge clk96) begin
        if (!as_n) begin
            req.addr  <= addr;
            req.rw    <= rw;
            req.uds_n <= uds_n;
            req.lds_n <= lds_n;
            req.wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

/* bus_device.sv */
// device stage with work, shared and palette ram, input ports, rom request and gcu ops
`timescale 1ns/1ps
`default_nettype none
`include "pipibibs_bus_settings.svh"

module bus_device (
    input  wire logic                   clk96,
    input  wire logic                   reset96,
    cpu_req_if.dst                      req,
    output logic                        rom_cs,
    output logic [16:0]                 rom_addr,
    input  wire logic                   rom_ok,
    input  wire logic [15:0]            rom_data,
    output pipibibs_bus_pkg::gcu_op_t   gcu_op,
    input  wire logic                   gcu_ack,
    input  wire logic [15:0]            gcu_dout,
    input  wire logic [9:0]             joystick1,
    input  wire logic [9:0]             joystick2,
    input  wire logic [3:0]             start_button,
    input  wire logic [3:0]             coin_input,
    input  wire logic                   service,
    input  wire logic                   dip_test,
    input  wire logic [7:0]             dipsw_a,
    input  wire logic [7:0]             dipsw_b,
    input  wire logic [7:0]             dipsw_c,
    input  wire logic [`PALRAM_AW-1:0]  palram_addr,
    output logic [15:0]                 palram_data,
    input  wire logic [`SRAM_AW-1:0]    sram_addr,
    input  wire logic [7:0]             sram_din,
    input  wire logic                   sram_we,
    output logic [7:0]                  sram_data,
    output logic                        dev_ready,
    output logic [15:0]                 dev_rdata,
    output logic                        dev_active
);
    import pipibibs_bus_pkg::*;

    logic [15:0] wram   [0:(1 << `WRAM_AW)-1];
    logic [15:0] palram [0:(1 << `PALRAM_AW)-1];
    logic [7:0]  sram   [0:(1 << `SRAM_AW)-1];

    logic [`WRAM_AW-1:0]   wram_a;
    logic [`PALRAM_AW-1:0] palram_a;
    logic [`SRAM_AW-1:0]   sram_a;
    logic        cpu_wr;
    logic [15:0] wram_q, palram_q;
    logic [7:0]  sram_q;
    logic [11:0] io_offs;
    logic [3:0]  gcu_offs;
    logic [7:0]  p1_ctrl, p2_ctrl, sys_bits;
    logic [15:0] io_q, rd_mux;
    logic        ready_src;
    gcu_op_t     gcu_next;

    assign wram_a   = req.addr[`WRAM_AW:1];
    assign palram_a = req.addr[`PALRAM_AW:1];
    assign sram_a   = req.addr[`SRAM_AW:1];
    assign cpu_wr   = req.valid && !req.rw;
    assign io_offs  = {req.addr[11:1], 1'b0};
    assign gcu_offs = {req.addr[3:1], 1'b0};
    assign dev_active = req.valid;

    // cabinet inputs are active low, the game expects active high
    assign p1_ctrl = {1'b0, ~joystick1[6], ~joystick1[5], ~joystick1[4],
                      ~joystick1[0], ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_ctrl = {1'b0, ~joystick2[6], ~joystick2[5], ~joystick2[4],
                      ~joystick2[0], ~joystick2[1], ~joystick2[2], ~joystick2[3]};
    assign sys_bits = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_ff @(posedge clk96) begin
        if (cpu_wr && req.region == WRAM) begin
            if (!req.uds_n) wram[wram_a][15:8] <= req.wdata[15:8];
            if (!req.lds_n) wram[wram_a][7:0]  <= req.wdata[7:0];
        end
        wram_q <= wram[wram_a];
    end

    // cpu writes and reads, video reads on its own port
    always_ff @(posedge clk96) begin
        if (cpu_wr && req.region == PALRAM) begin
            if (!req.uds_n) palram[palram_a][15:8] <= req.wdata[15:8];
            if (!req.lds_n) palram[palram_a][7:0]  <= req.wdata[7:0];
        end
        palram_q    <= palram[palram_a];
        palram_data <= palram[palram_addr];
    end

    // shared with the sound cpu, 68k sees it on d7..d0
    always_ff @(posedge clk96) begin
        if (cpu_wr && req.region == SRAM && !req.lds_n) sram[sram_a] <= req.wdata[7:0];
        if (sram_we) sram[sram_addr] <= sram_din;
        sram_q    <= sram[sram_a];
        sram_data <= sram[sram_addr];
    end

    always_comb begin
        case (io_offs)
            `IO_DSWA: io_q = {2{dipsw_a}};
            `IO_DSWB: io_q = {2{dipsw_b}};
            `IO_JMPR: io_q = {12'h000, dipsw_c[3:0]}; // region jumpers
            `IO_SYS:  io_q = {dipsw_c, sys_bits};
            `IO_IN1:  io_q = {2{p1_ctrl}};
            `IO_IN2:  io_q = {2{p2_ctrl}};
            default:  io_q = 16'h0000;
        endcase
    end

    always_comb begin
        gcu_next = NOP;
        if (req.rw) begin
            case (gcu_offs)
                4'h4:    gcu_next = READ_RAM_H;
                4'h6:    gcu_next = READ_RAM_L;
                default: gcu_next = NOP;
            endcase
        end else begin
            case (gcu_offs)
                4'h0:       gcu_next = SET_RAM_PTR;
                4'h4, 4'h6: gcu_next = WRITE_RAM;
                4'h8:       gcu_next = SELECT_REG;
                4'hC:       gcu_next = WRITE_REG;
                default:    gcu_next = NOP;
            endcase
        end
    end

    always_comb begin
        rd_mux    = 16'h0000;
        ready_src = 1'b1;
        case (req.region)
            ROM: begin
                rd_mux    = rom_data;
                ready_src = rom_cs && rom_ok;
            end
            WRAM:   rd_mux = wram_q;
            SRAM:   rd_mux = {2{sram_q}};
            PALRAM: rd_mux = palram_q;
            GCU: begin
                rd_mux    = gcu_dout;
                ready_src = gcu_ack || gcu_next == NOP; // no op, nothing to wait for
            end
            IO:      rd_mux = io_q;
            default: rd_mux = 16'h0000;
        endcase
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            rom_cs    <= 1'b0;
            gcu_op    <= NOP;
            dev_ready <= 1'b0;
        end else begin
            rom_cs <= req.region == ROM;
            if (req.region == GCU) gcu_op <= gcu_next;
            else if (gcu_ack)      gcu_op <= NOP; // gcu took it
            dev_ready <= req.valid && ready_src;
        end
    end

    always_ff @(posedge clk96) begin
        if (req.region == ROM) rom_addr <= req.addr[17:1];
        dev_rdata <= rd_mux;
    end

endmodule

`default_nettype wire

/* bus_dtack.sv */
// read data latch and dtack generation for the 68000 bus
`timescale 1ns/1ps
`default_nettype none

module bus_dtack (
    input  wire logic        clk96,
    input  wire logic        reset96,
    input  wire logic        as_n,
    input  wire logic        dev_ready,
    input  wire logic [15:0] dev_rdata,
    input  wire logic        dev_active,
    output logic             dtack_n,
    output logic [15:0]      din
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,   // device still busy
        ACK     // dtack low, data held
    } state_t;

    state_t state;
    logic   as_q;   // as_n one edge late, lines up release with valid

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            state   <= IDLE;
            as_q    <= 1'b1;
            dtack_n <= 1'b1;
            din     <= 16'h0000;
        end else begin
            as_q <= as_n;
            case (state)
                IDLE, WAIT: begin
                    if (dev_active && dev_ready) begin
                        state   <= ACK;
                        dtack_n <= 1'b0;
                        din     <= dev_rdata;
                    end else if (dev_active) begin
                        state <= WAIT;
                    end else begin
                        state <= IDLE;
                    end
                end
                ACK: begin
                    if (as_q) begin // strobe gone, cycle over
                        state   <= IDLE;
                        dtack_n <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* cpu_req_if.sv */
// interface for a decoded cpu access between the decode and device stages
`timescale 1ns/1ps
`default_nettype none

interface cpu_req_if;
    import pipibibs_bus_pkg::*;

    logic          valid;   // access in flight
    region_t       region;
    logic [23:1]   addr;    // word address
    logic          rw;      // 1 = read
    logic          uds_n;
    logic          lds_n;
    logic [15:0]   wdata;

    // decode side
    modport src (
        output valid, region, addr, rw, uds_n, lds_n, wdata
    );

    // device side
    modport dst (
        input valid, region, addr, rw, uds_n, lds_n, wdata
    );

endinterface

`default_nettype wire

/* pipibibs_bus.f */
+incdir+.
pipibibs_bus_pkg.sv
cpu_req_if.sv
bus_decode.sv
bus_device.sv
bus_dtack.sv
pipibibs_bus.sv
tb_pipibibs_bus.sv

/* pipibibs_bus.sv */
// top level of the main cpu bus with decode, device and dtack stages
`timescale 1ns/1ps
`default_nettype none

module pipibibs_bus (
    input  wire logic                  clk96,
    input  wire logic                  reset96,
    // 68000 side
    input  wire logic                  as_n,
    input  wire logic                  uds_n,
    input  wire logic                  lds_n,
    input  wire logic                  rw,
    input  wire logic [23:1]           addr,
    input  wire logic [15:0]           dout,    // cpu write data
    output logic                       dtack_n,
    output logic [15:0]                din,     // cpu read data
    // program rom
    output logic                       rom_cs,
    output logic [16:0]                rom_addr,
    input  wire logic                  rom_ok,
    input  wire logic [15:0]           rom_data,
    // graphics controller
    output pipibibs_bus_pkg::gcu_op_t  gcu_op,
    input  wire logic                  gcu_ack,
    input  wire logic [15:0]           gcu_dout,
    // cabinet
    input  wire logic [9:0]            joystick1,
    input  wire logic [9:0]            joystick2,
    input  wire logic [3:0]            start_button,
    input  wire logic [3:0]            coin_input,
    input  wire logic                  service,
    input  wire logic                  dip_test,
    input  wire logic [7:0]            dipsw_a,
    input  wire logic [7:0]            dipsw_b,
    input  wire logic [7:0]            dipsw_c,
    // video and sound cpu ports
    input  wire logic [10:0]           palram_addr,
    output logic [15:0]                palram_data,
    input  wire logic [10:0]           sram_addr,
    input  wire logic [7:0]            sram_din,
    input  wire logic                  sram_we,
    output logic [7:0]                 sram_data
);

    logic        dev_ready, dev_active;
    logic [15:0] dev_rdata;

    cpu_req_if req_bus ();

    bus_decode u_decode (
        .clk96   (clk96),   .reset96 (reset96),
        .as_n    (as_n),    .uds_n   (uds_n),   .lds_n (lds_n),
        .rw      (rw),      .addr    (addr),    .wdata (dout),
        .req     (req_bus.src)
    );

    bus_device u_device (
        .clk96        (clk96),        .reset96     (reset96),
        .req          (req_bus.dst),
        .rom_cs       (rom_cs),       .rom_addr    (rom_addr),
        .rom_ok       (rom_ok),       .rom_data    (rom_data),
        .gcu_op       (gcu_op),       .gcu_ack     (gcu_ack),     .gcu_dout (gcu_dout),
        .joystick1    (joystick1),    .joystick2   (joystick2),
        .start_button (start_button), .coin_input  (coin_input),
        .service      (service),      .dip_test    (dip_test),
        .dipsw_a      (dipsw_a),      .dipsw_b     (dipsw_b),     .dipsw_c  (dipsw_c),
        .palram_addr  (palram_addr),  .palram_data (palram_data),
        .sram_addr    (sram_addr),    .sram_din    (sram_din),
        .sram_we      (sram_we),      .sram_data   (sram_data),
        .dev_ready    (dev_ready),    .dev_rdata   (dev_rdata),   .dev_active (dev_active)
    );

    bus_dtack u_dtack (
        .clk96      (clk96),      .reset96   (reset96),   .as_n (as_n),
        .dev_ready  (dev_ready),  .dev_rdata (dev_rdata), .dev_active (dev_active),
        .dtack_n    (dtack_n),    .din       (din)
    );

endmodule

`default_nettype wire

/* pipibibs_bus_pkg.sv */
// package with the bus region and gcu operation types
`default_nettype none

package pipibibs_bus_pkg;

    // which device a decoded access goes to
    typedef enum logic [2:0] {
        ROM,
        WRAM,
        SRAM,
        PALRAM,
        GCU,
        IO,
        NONE    // nothing on the map, reads as zero
    } region_t;

    // one level per gcu operation, NOP when nothing is requested
    typedef enum logic [2:0] {
        NOP,
        SET_RAM_PTR,
        READ_RAM_H,
        READ_RAM_L,
        WRITE_RAM,
        SELECT_REG,
        WRITE_REG
    } gcu_op_t;

endpackage

`default_nettype wire

/* pipibibs_bus_settings.svh */
// memory map bases, ram address widths and i/o port offsets of the main cpu bus
`ifndef PIPIBIBS_BUS_SETTINGS_SVH
`define PIPIBIBS_BUS_SETTINGS_SVH

// byte addresses of the memory map
`define ROM_TOP      24'h040000 // program rom runs from 0 up to here
`define WRAM_BASE    24'h080000 // matched on bits 23:16
`define PALRAM_BASE  24'h0C0000 // matched on bits 23:12
`define GCU_BASE     24'h140000 // matched on bits 23:16
`define SRAM_BASE    24'h190000 // matched on bits 23:12
`define IO_BASE      24'h19C000 // matched on bits 23:12

// word address widths of the on-board rams
`define WRAM_AW      13
`define PALRAM_AW    11
`define SRAM_AW      11

// cabinet port offsets inside the i/o window
`define IO_DSWA      12'h020
`define IO_DSWB      12'h024
`define IO_JMPR      12'h028
`define IO_SYS       12'h02C
`define IO_IN1       12'h030
`define IO_IN2       12'h034

`endif

/* tb_pipibibs_bus.sv */
// testbench for the main cpu bus with bus-master tasks, rom and gcu models and checks
`timescale 1ns/1ps
`default_nettype none
`include "pipibibs_bus_settings.svh"

module tb_pipibibs_bus;
    import pipibibs_bus_pkg::*;

    localparam int access_count  = 60;   // upper bound on bus cycles below
    localparam int access_cycles = 24;   // worst case incl. 7 wait states and release
    localparam int timeout_limit = 16 + access_count * access_cycles + 64;

    logic        clk96 = 1'b0;
    logic        reset96, as_n, uds_n, lds_n, rw, dtack_n;
    logic [23:1] addr;
    logic [15:0] dout, din, rom_data, gcu_dout, palram_data;
    logic [16:0] rom_addr;
    logic        rom_cs, service, dip_test, sram_we;
    logic        rom_ok  = 1'b0;    // from the rom model
    logic        gcu_ack = 1'b0;    // from the gcu model
    gcu_op_t     gcu_op;
    logic [9:0]  joystick1, joystick2;
    logic [3:0]  start_button, coin_input;
    logic [7:0]  dipsw_a, dipsw_b, dipsw_c, sram_din, sram_data;
    logic [10:0] palram_addr, sram_addr;

    logic [31:0] lfsr = 32'h141d_df65;
    int          cycle_count = 0;
    int          rom_delay, gcu_delay;
    int          rom_wait = 0;
    int          gcu_wait = 0;
    // snapshot taken when dtack_n is seen low
    logic [15:0] rd_data;
    int          ack_edges;
    logic        ack_rom_ok, ack_rom_cs, ack_gcu_ack;
    logic [16:0] ack_rom_addr;
    gcu_op_t     ack_gcu_op;

    // gcu accesses with the op each one should raise
    logic [3:0]  g_offs [9] = '{4'h4, 4'h6, 4'h0, 4'h0, 4'h4, 4'h6, 4'h8, 4'hC, 4'h2};
    logic        g_rd   [9] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    gcu_op_t     g_op   [9] = '{READ_RAM_H, READ_RAM_L, NOP, SET_RAM_PTR, WRITE_RAM,
                                WRITE_RAM, SELECT_REG, WRITE_REG, NOP};

    pipibibs_bus u_pipibibs_bus (.*);

    always #2 clk96 = ~clk96;

    always @(posedge clk96) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("bus cycle never finished, run stopped at the cycle limit");
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] rom_word(input logic [16:0] wa);
        return wa[15:0] ^ {wa[16], 15'h3a5c};
    endfunction

    // rom model raises ok after rom_delay edges and holds it while rom_cs is high
    assign rom_data = rom_word(rom_addr);
    always @(posedge clk96) begin
        if (!rom_cs) begin
            rom_wait <= 0;
            rom_ok   <= 1'b0;
        end else if (rom_wait == rom_delay) rom_ok <= 1'b1;
        else rom_wait <= rom_wait + 1;
    end

    // gcu model holds ack until the op level drops
    always @(posedge clk96) begin
        if (gcu_op == NOP) begin
            gcu_wait <= 0;
            gcu_ack  <= 1'b0;
        end else if (gcu_wait == gcu_delay) gcu_ack <= 1'b1;
        else gcu_wait <= gcu_wait + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic require_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("check failed: %s", what);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // one 68000 cycle with strobes_n as {uds_n, lds_n}
    task automatic bus_cycle(input logic rd, input logic [23:0] ba,
                             input logic [1:0] strobes_n, input logic [15:0] wd);
        @(posedge clk96);
        addr  <= ba[23:1];
        rw    <= rd;
        uds_n <= strobes_n[1];
        lds_n <= strobes_n[0];
        dout  <= wd;
        as_n  <= 1'b0;
        ack_edges = 0;
        do begin
            @(posedge clk96);
            ack_edges++;
            #1;
        end while (dtack_n);
        ack_edges    = ack_edges - 1; // counted from edge 0
        rd_data      = din;
        ack_rom_ok   = rom_ok;
        ack_rom_cs   = rom_cs;
        ack_rom_addr = rom_addr;
        ack_gcu_ack  = gcu_ack;
        ack_gcu_op   = gcu_op;
        @(posedge clk96);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        do begin
            @(posedge clk96);
            #1;
        end while (!dtack_n);
        repeat (3) @(posedge clk96);
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] wd, wd2, exp;
        logic [12:0] a;
        logic [7:0]  p1, p2, sys;
        reset96 = 1'b1;
        {as_n, uds_n, lds_n, rw} = 4'b1111;
        addr = '0;
        dout = '0;
        gcu_dout = '0;
        {joystick1, joystick2, start_button, coin_input} = '0;
        {service, dip_test, dipsw_a, dipsw_b, dipsw_c} = '0;
        {palram_addr, sram_addr, sram_din, sram_we} = '0;
        rom_delay = 0;
        gcu_delay = 0;
        repeat (16) @(posedge clk96);
        reset96 <= 1'b0;
        @(posedge clk96);
        #1;
        require_true(dtack_n && !rom_cs && gcu_op == NOP && din == 16'h0,
                     "outputs idle after reset");

        // work ram word and byte lane writes with dtack at edge 3
        for (int k = 0; k < 4; k++) begin
            take_bits(13, r);
            a = r[12:0];
            take_bits(32, r);
            wd  = r[15:0];
            wd2 = r[31:16];
            bus_cycle(1'b0, `WRAM_BASE | 24'({a, 1'b0}), 2'b00, wd);
            bus_cycle(1'b1, `WRAM_BASE | 24'({a, 1'b0}), 2'b00, 16'h0);
            check_value("din", 32'(rd_data), 32'(wd));
            check_value("wram dtack edges", ack_edges, 3);
            bus_cycle(1'b0, `WRAM_BASE | 24'({a, 1'b0}), k[0] ? 2'b01 : 2'b10, wd2);
            exp = k[0] ? {wd2[15:8], wd[7:0]} : {wd[15:8], wd2[7:0]};
            bus_cycle(1'b1, `WRAM_BASE | 24'({a, 1'b0}), 2'b00, 16'h0);
            check_value("din", 32'(rd_data), 32'(exp));
        end

        // shared ram from both ports
        for (int k = 0; k < 2; k++) begin
            take_bits(27, r);
            bus_cycle(1'b0, `SRAM_BASE | 24'({r[10:0], 1'b0}), 2'b10, r[26:11]);
            @(posedge clk96);
            sram_addr <= r[10:0];
            repeat (2) @(posedge clk96);
            #1;
            check_value("sram_data", 32'(sram_data), 32'(r[18:11]));
            take_bits(19, r);
            @(posedge clk96);
            sram_addr <= r[10:0];
            sram_din  <= r[18:11];
            sram_we   <= 1'b1;
            @(posedge clk96);
            sram_we <= 1'b0;
            bus_cycle(1'b1, `SRAM_BASE | 24'({r[10:0], 1'b0}), 2'b00, 16'h0);
            check_value("din", 32'(rd_data), 32'({r[18:11], r[18:11]}));
        end

        // palette ram read back on the video port and by the cpu
        for (int k = 0; k < 3; k++) begin
            take_bits(27, r);
            bus_cycle(1'b0, `PALRAM_BASE | 24'({r[10:0], 1'b0}), 2'b00, r[26:11]);
            @(posedge clk96);
            palram_addr <= r[10:0];
            repeat (2) @(posedge clk96);
            #1;
            check_value("palram_data", 32'(palram_data), 32'(r[26:11]));
            bus_cycle(1'b1, `PALRAM_BASE | 24'({r[10:0], 1'b0}), 2'b00, 16'h0);
            check_value("din palram", 32'(rd_data), 32'(r[26:11]));
        end

        // cabinet ports
        take_bits(30, r);
        @(posedge clk96);
        joystick1    <= r[9:0];
        joystick2    <= r[19:10];
        start_button <= r[23:20];
        coin_input   <= r[27:24];
        service      <= r[28];
        dip_test     <= r[29];
        take_bits(24, r);
        dipsw_a <= r[7:0];
        dipsw_b <= r[15:8];
        dipsw_c <= r[23:16];
        @(posedge clk96);
        p1  = {1'b0, ~joystick1[6:4], ~joystick1[0], ~joystick1[1], ~joystick1[2],
               ~joystick1[3]};
        p2  = {1'b0, ~joystick2[6:4], ~joystick2[0], ~joystick2[1], ~joystick2[2],
               ~joystick2[3]};
        sys = {1'b0, ~start_button[1:0], ~coin_input[1:0], ~dip_test, 1'b0, ~service};
        bus_cycle(1'b1, `IO_BASE | 24'(`IO_DSWA), 2'b00, 16'h0);
        check_value("din dswa", 32'(rd_data), 32'({dipsw_a, dipsw_a}));
        bus_cycle(1'b1, `IO_BASE | 24'(`IO_DSWB), 2'b00, 16'h0);
        check_value("din dswb", 32'(rd_data), 32'({dipsw_b, dipsw_b}));
        bus_cycle(1'b1, `IO_BASE | 24'(`IO_JMPR), 2'b00, 16'h0);
        check_value("din jumpers", 32'(rd_data), 32'(dipsw_c[3:0]));
        bus_cycle(1'b1, `IO_BASE | 24'(`IO_SYS), 2'b00, 16'h0);
        check_value("din system", 32'(rd_data), 32'({dipsw_c, sys}));
        bus_cycle(1'b1, `IO_BASE | 24'(`IO_IN1), 2'b00, 16'h0);
        check_value("din in1", 32'(rd_data), 32'({p1, p1}));
        bus_cycle(1'b1, `IO_BASE | 24'(`IO_IN2), 2'b00, 16'h0);
        check_value("din in2", 32'(rd_data), 32'({p2, p2}));
        bus_cycle(1'b1, `IO_BASE | 24'h040, 2'b00, 16'h0);
        check_value("din unmapped io", 32'(rd_data), 0);
        bus_cycle(1'b1, 24'h100000, 2'b00, 16'h0);
        check_value("din unmapped", 32'(rd_data), 0);
        check_value("unmapped dtack edges", ack_edges, 3);

        // program rom with random wait states
        for (int k = 0; k < 6; k++) begin
            take_bits(20, r);
            rom_delay = int'(r[19:17]);
            bus_cycle(1'b1, 24'({r[16:0], 1'b0}), 2'b00, 16'h0);
            require_true(ack_rom_cs && ack_rom_ok, "rom dtack before rom_ok");
            check_value("rom_addr", 32'(ack_rom_addr), 32'(r[16:0]));
            check_value("din rom", 32'(rd_data), 32'(rom_word(r[16:0])));
            check_value("rom dtack edges", ack_edges, rom_delay + 4);
        end

        // gcu ops by offset and direction
        for (int k = 0; k < 9; k++) begin
            take_bits(19, r);
            gcu_delay = int'(r[18:16]);
            gcu_dout <= r[15:0];
            bus_cycle(g_rd[k], `GCU_BASE | 24'(g_offs[k]), 2'b00, r[15:0]);
            check_value("gcu_op", 32'(ack_gcu_op), 32'(g_op[k]));
            if (g_op[k] != NOP) begin
                require_true(ack_gcu_ack, "gcu dtack before gcu_ack");
                check_value("gcu dtack edges", ack_edges, gcu_delay + 4);
            end else begin
                check_value("gcu dtack edges", ack_edges, 3);
            end
            if (g_rd[k]) check_value("din gcu", 32'(rd_data), 32'(r[15:0]));
        end
        #1;
        require_true(gcu_op == NOP && !rom_cs && dtack_n, "strobes idle at end");

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
